//--- Makefile
# Verilator simulation of the direct mapped cache

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

# build, run, then look for the failure line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
src/cache_pkg.sv
src/miss_fsm.sv
src/tag_store.sv
src/data_store.sv
src/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

//--- src/cache_pkg.sv
// cache_pkg: word and block widths, cache geometry, miss state codes, address union

package cache_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int WORD_W       = 32;   // processor data word
    localparam int ADDR_W       = 30;   // processor word address
    localparam int BLOCK_W      = 128;  // one line, also memory data width
    localparam int BLOCK_ADDR_W = 28;   // memory block address

    // ------------------------------------------------------------------
    // geometry, direct mapped
    // ------------------------------------------------------------------
    localparam int OFFSET_W   = 2;   // 4 words per block
    localparam int NUM_BLOCKS = 8;
    localparam int INDEX_W    = 3;
    localparam int TAG_W      = 25;

    // miss controller states
    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_WRITE_BACK = 2'd1;
    localparam logic [1:0] ST_FILL       = 2'd2;

    // view used by the tag and data stores
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_split_t;

    // view used by the memory request
    typedef struct packed {
        logic [BLOCK_ADDR_W-1:0] block;
        logic [OFFSET_W-1:0]     word;
    } block_split_t;

    typedef union packed {
        addr_split_t  cache;
        block_split_t mem;
    } proc_addr_u;

endpackage

//--- src/data_store.sv
// data_store: block array with word select, single word write and whole block fill

`timescale 1ns/1ns

module data_store (
    input  logic                            clk,
    input  cache_pkg::proc_addr_u           proc_addr,
    input  logic [cache_pkg::WORD_W-1:0]    proc_wdata,
    input  logic                            word_write,
    input  logic                            fill,
    input  logic [cache_pkg::BLOCK_W-1:0]   mem_rdata,
    output logic [cache_pkg::WORD_W-1:0]    proc_rdata,
    output logic [cache_pkg::BLOCK_W-1:0]   victim_block
);

    logic [cache_pkg::BLOCK_W-1:0]  blocks [cache_pkg::NUM_BLOCKS];

    logic [cache_pkg::INDEX_W-1:0]  index;
    logic [cache_pkg::OFFSET_W-1:0] offset;
    logic [cache_pkg::BLOCK_W-1:0]  line;

    assign index  = proc_addr.cache.index;
    assign offset = proc_addr.cache.offset;
    assign line   = blocks[index];

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------

    // selected word, valid whenever the processor is not stalled
    assign proc_rdata = line[offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];

    // indexed line is what a write-back sends out
    assign victim_block = line;

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill) begin
            blocks[index] <= mem_rdata;    // whole block from memory
        end else if (word_write) begin
            // word 0 sits in the low 32 bits of the block
            blocks[index][offset*cache_pkg::WORD_W +: cache_pkg::WORD_W] <= proc_wdata;
        end
    end

endmodule

//--- src/dcache_top.sv
// dcache_top: direct mapped write-back cache built from the miss FSM and the two stores

`timescale 1ns/1ns

module dcache_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // processor port
    input  logic                                 proc_read,
    input  logic                                 proc_write,
    input  logic [cache_pkg::ADDR_W-1:0]         proc_addr,
    input  logic [cache_pkg::WORD_W-1:0]         proc_wdata,
    output logic [cache_pkg::WORD_W-1:0]         proc_rdata,
    output logic                                 proc_stall,
    // memory port
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [cache_pkg::BLOCK_ADDR_W-1:0]   mem_addr,
    output logic [cache_pkg::BLOCK_W-1:0]        mem_wdata,
    input  logic [cache_pkg::BLOCK_W-1:0]        mem_rdata,
    input  logic                                 mem_ready
);

    // ------------------------------------------------------------------
    // internal strobes and lookup results
    // ------------------------------------------------------------------
    logic                          word_write;   // write hit in idle
    logic                          fill;         // fill state with mem_ready
    logic                          hit;
    logic                          victim_dirty;
    logic [cache_pkg::TAG_W-1:0]   victim_tag;

    miss_fsm i_miss_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .word_write   (word_write),
        .fill         (fill),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr)
    );

    tag_store i_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_addr    (proc_addr),
        .word_write   (word_write),
        .fill         (fill),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // victim block goes straight out as write-back data
    data_store i_data_store (
        .clk          (clk),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .word_write   (word_write),
        .fill         (fill),
        .mem_rdata    (mem_rdata),
        .proc_rdata   (proc_rdata),
        .victim_block (mem_wdata)
    );

endmodule

//--- src/miss_fsm.sv
// miss_fsm: miss controller, processor stall, word write and fill strobes, memory request

`timescale 1ns/1ns

module miss_fsm (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 proc_read,
    input  logic                                 proc_write,
    input  cache_pkg::proc_addr_u                proc_addr,
    input  logic                                 hit,
    input  logic                                 victim_dirty,
    input  logic [cache_pkg::TAG_W-1:0]          victim_tag,
    input  logic                                 mem_ready,
    output logic                                 proc_stall,
    output logic                                 word_write,
    output logic                                 fill,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [cache_pkg::BLOCK_ADDR_W-1:0]   mem_addr
);

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       request;    // read or write level from the processor
    logic       miss;

    assign request = proc_read | proc_write;
    assign miss    = request & ~hit;

    // ------------------------------------------------------------------
    // processor side
    // ------------------------------------------------------------------

    // stall rises in the request cycle of a miss and falls with the hit
    // that follows the fill
    assign proc_stall = miss;

    // write hits only complete from idle
    assign word_write = (state == cache_pkg::ST_IDLE) & proc_write & hit;

    // block, tag and valid are written at the edge where memory answers
    assign fill = (state == cache_pkg::ST_FILL) & mem_ready;

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::ST_IDLE: begin
                if (miss) begin
                    // victim_dirty already includes the valid bit
                    state_nxt = victim_dirty ? cache_pkg::ST_WRITE_BACK
                                             : cache_pkg::ST_FILL;
                end
            end
            cache_pkg::ST_WRITE_BACK: begin
                if (mem_ready) begin
                    state_nxt = cache_pkg::ST_FILL;
                end
            end
            cache_pkg::ST_FILL: begin
                if (mem_ready) begin
                    state_nxt = cache_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = cache_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cache_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // memory side, levels held for the whole state
    // ------------------------------------------------------------------
    assign mem_write = (state == cache_pkg::ST_WRITE_BACK);
    assign mem_read  = (state == cache_pkg::ST_FILL);

    // write-back goes to the victim's block, fill to the missing one
    always_comb begin
        if (state == cache_pkg::ST_WRITE_BACK) begin
            mem_addr = {victim_tag, proc_addr.cache.index};
        end else begin
            mem_addr = proc_addr.mem.block;  // upper 28 bits of the word address
        end
    end

endmodule

//--- src/tag_store.sv
// tag_store: per-line valid, dirty and tag arrays, hit compare and victim lookup

`timescale 1ns/1ns

module tag_store (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cache_pkg::proc_addr_u         proc_addr,
    input  logic                          word_write,
    input  logic                          fill,
    output logic                          hit,
    output logic                          victim_dirty,
    output logic [cache_pkg::TAG_W-1:0]   victim_tag
);

    logic [cache_pkg::NUM_BLOCKS-1:0] valid;
    logic [cache_pkg::NUM_BLOCKS-1:0] dirty;
    logic [cache_pkg::TAG_W-1:0]      tags [cache_pkg::NUM_BLOCKS];

    logic [cache_pkg::INDEX_W-1:0]    index;
    logic [cache_pkg::TAG_W-1:0]      req_tag;
    logic [cache_pkg::TAG_W-1:0]      line_tag;

    assign index    = proc_addr.cache.index;
    assign req_tag  = proc_addr.cache.tag;
    assign line_tag = tags[index];

    // ------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------

    // a line hits only when valid and the stored tag matches
    assign hit = valid[index] & (line_tag == req_tag);

    // the resident line is the victim on a miss
    assign victim_dirty = valid[index] & dirty[index];
    assign victim_tag   = line_tag;

    // ------------------------------------------------------------------
    // update
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;   // all lines invalid
            dirty <= '0;
            for (int i = 0; i < cache_pkg::NUM_BLOCKS; i++) begin
                tags[i] <= '0;
            end
        end else begin
            if (fill) begin
                // new block arrives clean, a write miss dirties it later
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;
                tags[index]  <= req_tag;
            end else if (word_write) begin
                dirty[index] <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/mem_model.sv
// mem_model: block memory with a fixed response delay, preloaded words and stored write-backs

`timescale 1ns/1ns

module mem_model #(
    parameter int LATENCY = 2   // cycles from request to mem_ready
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 mem_read,
    input  logic                                 mem_write,
    input  logic [cache_pkg::BLOCK_ADDR_W-1:0]   mem_addr,
    input  logic [cache_pkg::BLOCK_W-1:0]        mem_wdata,
    output logic [cache_pkg::BLOCK_W-1:0]        mem_rdata,
    output logic                                 mem_ready
);

    // only blocks that were written back are kept here
    logic [cache_pkg::BLOCK_W-1:0] blocks [logic [cache_pkg::BLOCK_ADDR_W-1:0]];
    int                            cnt;

    // preload value of a word, built from the whole word address
    function automatic logic [31:0] init_word(input logic [29:0] waddr);
        return {waddr, 2'b11} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [127:0] read_block(input logic [27:0] baddr);
        logic [127:0] blk;
        if (blocks.exists(baddr)) begin
            return blocks[baddr];
        end
        for (int i = 0; i < 4; i++) begin
            blk[i*32 +: 32] = init_word({baddr, 2'(i)});   // word 0 in the low bits
        end
        return blk;
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        cnt       = 0;
    end

    // ------------------------------------------------------------------
    // request handling, one ready strobe per request
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= 0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            if ((mem_read || mem_write) && !mem_ready) begin
                if (cnt == LATENCY - 1) begin
                    cnt       <= 0;
                    mem_ready <= 1'b1;
                    if (mem_write) begin
                        blocks[mem_addr] = mem_wdata;
                    end else begin
                        mem_rdata <= read_block(mem_addr);
                    end
                end else begin
                    cnt <= cnt + 1;
                end
            end else begin
                cnt <= 0;   // restart for the next state
            end
        end
    end

endmodule

//--- testbench/tb_dcache.sv
// tb_dcache: clock, reset, cache stimulus, shadow memory scoreboard, assertions and report

`timescale 1ns/1ns

module tb_dcache;

    localparam int MEM_LATENCY   = 3;
    localparam int STALL_TIMEOUT = 40;   // cycles per access

    logic                                 clk;
    logic                                 rst_n;
    logic                                 proc_read;
    logic                                 proc_write;
    logic [cache_pkg::ADDR_W-1:0]         proc_addr;
    logic [cache_pkg::WORD_W-1:0]         proc_wdata;
    logic [cache_pkg::WORD_W-1:0]         proc_rdata;
    logic                                 proc_stall;
    logic                                 mem_read;
    logic                                 mem_write;
    logic [cache_pkg::BLOCK_ADDR_W-1:0]   mem_addr;
    logic [cache_pkg::BLOCK_W-1:0]        mem_wdata;
    logic [cache_pkg::BLOCK_W-1:0]        mem_rdata;
    logic                                 mem_ready;

    integer      seed;
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_start_errors;
    logic [31:0] shadow [logic [29:0]];   // words written by the processor

    // what the last access saw on the memory port
    logic         first_stall;
    logic         seen_read;
    logic         seen_write;
    logic         read_first;
    logic [27:0]  wb_addr;
    logic [27:0]  fill_addr;
    logic [127:0] wb_data;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    dcache_top i_dcache_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    mem_model #(.LATENCY(MEM_LATENCY)) i_mem_model (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    // ------------------------------------------------------------------
    // protocol assertions
    // ------------------------------------------------------------------
    rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin
            $display("Error at %0t: mem_read and mem_write high together", $time);
            errors++;
        end

    ready_in_request: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> (mem_read || mem_write))
        else begin
            $display("Error at %0t: mem_ready with no memory request", $time);
            errors++;
        end

    idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(proc_read || proc_write) |-> !proc_stall)
        else begin
            $display("Error at %0t: proc_stall high without a request", $time);
            errors++;
        end

    // ------------------------------------------------------------------
    // scoreboard
    // ------------------------------------------------------------------
    function automatic logic [31:0] preload_word(input logic [29:0] waddr);
        return {waddr, 2'b11} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] expected_word(input logic [29:0] waddr);
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return preload_word(waddr);
    endfunction

    function automatic logic [127:0] expected_block(input logic [27:0] baddr);
        logic [127:0] blk;
        for (int i = 0; i < 4; i++) begin
            blk[i*32 +: 32] = expected_word({baddr, 2'(i)});
        end
        return blk;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        assert (got == expected)
            else begin
                $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, expected);
                errors++;
            end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
            else begin
                $display("Error at %0t: %s", $time, what);
                errors++;
            end
    endtask

    task automatic sample_memory();
        if (mem_write && !seen_write) begin
            seen_write = 1'b1;
            wb_addr    = mem_addr;
            wb_data    = mem_wdata;
            read_first = seen_read;   // write-back must come first
        end
        if (mem_read && !seen_read) begin
            seen_read = 1'b1;
            fill_addr = mem_addr;
        end
    endtask

    // one processor access, held until the stall falls
    task automatic access(input logic is_write, input logic [29:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = wdata;
        seen_read  = 1'b0;
        seen_write = 1'b0;
        read_first = 1'b0;
        #10;
        first_stall = proc_stall;
        sample_memory();
        while (proc_stall && cycles < STALL_TIMEOUT) begin
            @(negedge clk);
            #10;
            cycles++;
            sample_memory();
        end
        if (proc_stall) begin
            $display("Timeout: proc_stall still high after %0d cycles at %0t", cycles, $time);
            $display("*** FAILED ***");
            $finish;
        end
        rdata = proc_rdata;
        if (is_write) begin
            shadow[addr] = wdata;   // committed at the coming edge
        end
        @(negedge clk);
        sample_memory();   // state after the commit edge
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]  rnd;
        logic [31:0]  data;
        logic [31:0]  wdata_a;
        logic [31:0]  wdata_c;
        logic [29:0]  addr_a;
        logic [29:0]  addr_b;
        logic [29:0]  addr_c;
        logic [29:0]  addr_d;
        logic [127:0] victim;

        seed              = 32'he9df_5888;
        rst_n             = 1'b0;
        proc_read         = 1'b0;
        proc_write        = 1'b0;
        proc_addr         = '0;
        proc_wdata        = '0;
        errors            = 0;
        tests             = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        first_stall       = 1'b0;
        seen_read         = 1'b0;
        seen_write        = 1'b0;
        read_first        = 1'b0;

        rnd    = $random(seed);
        addr_a = {rnd[29:2], 2'b00};
        rnd    = $random(seed);
        addr_b = addr_a ^ {rnd[24:0] | 25'd1, 5'd0};   // same index, other tag
        rnd    = $random(seed);
        addr_c = {rnd[29:5], addr_a[4:2] ^ 3'd1, 2'b10};
        rnd    = $random(seed);
        addr_d = addr_c ^ {rnd[24:0] | 25'd1, 5'd0};
        wdata_a = $random(seed);
        wdata_c = $random(seed);

        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        #10;
        check_value("mem_read", 128'(mem_read), 128'd0);
        check_value("mem_write", 128'(mem_write), 128'd0);
        check_value("proc_stall", 128'(proc_stall), 128'd0);
        finish_test("reset");

        access(1'b0, addr_a | 30'd1, 32'd0, data);
        check_true(first_stall, "read miss did not stall in its request cycle");
        check_true(seen_read, "no memory read on a clean read miss");
        check_true(!seen_write, "memory write on a clean read miss");
        check_value("mem_addr", 128'(fill_addr), 128'(addr_a[29:2]));
        check_value("proc_rdata", 128'(data), 128'(expected_word(addr_a | 30'd1)));
        finish_test("read miss clean");

        access(1'b0, addr_a | 30'd2, 32'd0, data);
        check_true(!first_stall, "read hit stalled");
        check_true(!seen_read && !seen_write, "memory request on a read hit");
        check_value("proc_rdata", 128'(data), 128'(expected_word(addr_a | 30'd2)));
        finish_test("read hit");

        access(1'b1, addr_a | 30'd3, wdata_a, data);
        check_true(!first_stall, "write hit stalled");
        check_true(!seen_read && !seen_write, "memory request on a write hit");
        access(1'b0, addr_a | 30'd3, 32'd0, data);
        check_value("proc_rdata", 128'(data), 128'(wdata_a));
        finish_test("write hit");

        victim = expected_block(addr_a[29:2]);
        access(1'b0, addr_b, 32'd0, data);
        check_true(seen_write, "no write-back of the dirty victim");
        check_true(!read_first, "memory read issued before the write-back");
        check_value("mem_addr", 128'(wb_addr), 128'(addr_a[29:2]));
        check_value("mem_wdata", wb_data, victim);
        check_value("mem_addr", 128'(fill_addr), 128'(addr_b[29:2]));
        check_value("proc_rdata", 128'(data), 128'(expected_word(addr_b)));
        finish_test("dirty eviction");

        access(1'b1, addr_c, wdata_c, data);
        check_true(first_stall, "write miss did not stall");
        check_true(seen_read && !seen_write, "write miss on a clean line without a plain fill");
        check_value("mem_addr", 128'(fill_addr), 128'(addr_c[29:2]));
        access(1'b0, addr_c, 32'd0, data);
        check_true(!first_stall, "read after the write miss stalled");
        check_value("proc_rdata", 128'(data), 128'(wdata_c));
        victim = expected_block(addr_c[29:2]);
        access(1'b0, addr_d, 32'd0, data);
        check_true(seen_write, "block filled by a write miss was not written back");
        check_value("mem_addr", 128'(wb_addr), 128'(addr_c[29:2]));
        check_value("mem_wdata", wb_data, victim);
        // clean line now, so the refill comes straight from memory
        access(1'b0, addr_c, 32'd0, data);
        check_true(!seen_write, "write-back of a clean line");
        check_value("proc_rdata", 128'(data), 128'(wdata_c));
        finish_test("write miss");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
